//--- source/dcache_pkg.sv
package dcache_pkg;

    localparam int addr_w   = 32;
    localparam int tag_w    = 20;  // addr[31:12]
    localparam int index_w  = 7;   // addr[11:5]
    localparam int offset_w = 5;   // word select in addr[4:2]
    localparam int sets     = 2 ** index_w;
    localparam int ways     = 2;
    localparam int line_w   = 256;

    typedef logic [31:0] word_t;

    localparam int banks = line_w / $bits(word_t);

    // bank 0 sits in the low word
    typedef word_t [banks-1:0] line_t;

    typedef struct packed {
        logic              write;
        logic              uncached;
        logic [3:0]        strb;
        logic [addr_w-1:0] addr;
        word_t             wdata;
    } cpu_req_t;

    typedef enum logic [1:0] {
        line_read,
        line_write,
        word_read,
        word_write
    } mem_kind_e;

    typedef struct packed {
        mem_kind_e         kind;
        logic [addr_w-1:0] addr;  // line aligned for line kinds
        logic [3:0]        strb;  // word_write only
        line_t             data;  // single word goes in bank 0
    } mem_req_t;

    typedef enum logic [1:0] {
        idle,
        write_back,
        refill,
        uncached
    } ctrl_state_e;

endpackage

//--- source/cache_ram.sv
`timescale 1ns/10ps

module cache_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 128
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output logic [WIDTH-1:0]         rd_data_o,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  logic [WIDTH-1:0]         wr_data_i
);

    logic [WIDTH-1:0] mem [DEPTH];

    // read-first so a same-edge write shows up on the next read
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
        if (we_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

//--- source/dcache_way.sv
`timescale 1ns/10ps

module dcache_way
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic [index_w-1:0] rd_index_i,
    input  logic [tag_w-1:0]   lookup_tag_i,
    input  logic               valid_i,
    input  logic               we_i,
    input  logic [banks-1:0]   bank_mask_i,
    input  logic [index_w-1:0] wr_index_i,
    input  logic [tag_w-1:0]   wr_tag_i,
    input  line_t              wr_line_i,
    output logic               hit_o,
    output logic [tag_w-1:0]   tag_o,
    output line_t              line_o
);

    logic tag_we;

    assign tag_we = we_i && (&bank_mask_i);  // full mask means a fill

    cache_ram #(
        .WIDTH(tag_w),
        .DEPTH(sets)
    ) u_tag_ram (
        .clk      (clk),
        .rd_addr_i(rd_index_i),
        .rd_data_o(tag_o),
        .we_i     (tag_we),
        .wr_addr_i(wr_index_i),
        .wr_data_i(wr_tag_i)
    );

    for (genvar b = 0; b < banks; b++) begin : g_bank
        cache_ram #(
            .WIDTH($bits(word_t)),
            .DEPTH(sets)
        ) u_bank_ram (
            .clk      (clk),
            .rd_addr_i(rd_index_i),
            .rd_data_o(line_o[b]),
            .we_i     (we_i && bank_mask_i[b]),
            .wr_addr_i(wr_index_i),
            .wr_data_i(wr_line_i[b])
        );
    end

    assign hit_o = valid_i && (tag_o == lookup_tag_i);

endmodule

//--- source/dcache_meta.sv
`timescale 1ns/10ps

module dcache_meta
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic [index_w-1:0] index_i,
    input  logic               fill_i,
    input  logic               fill_way_i,
    input  logic               fill_dirty_i,
    input  logic               touch_i,
    input  logic               touch_way_i,
    input  logic               store_i,
    output logic [ways-1:0]    valid_o,
    output logic               lru_o,
    output logic               victim_dirty_o
);

    logic [sets-1:0]           lru_q;  // value is the way to replace next
    logic [sets-1:0][ways-1:0] valid_q;
    logic [sets-1:0][ways-1:0] dirty_q;

    assign valid_o        = valid_q[index_i];
    assign lru_o          = lru_q[index_i];
    assign victim_dirty_o = dirty_q[index_i][lru_q[index_i]];

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q   <= '0;
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_i) begin
            valid_q[index_i][fill_way_i] <= 1'b1;
            dirty_q[index_i][fill_way_i] <= fill_dirty_i;
            lru_q[index_i]               <= ~fill_way_i;
        end else begin
            if (touch_i) begin
                lru_q[index_i] <= ~touch_way_i;  // other way becomes victim
            end
            if (store_i) begin
                dirty_q[index_i][touch_way_i] <= 1'b1;
            end
        end
    end

endmodule

//--- source/dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cpu_valid_i,
    input  cpu_req_t                   cpu_req_i,
    output logic                       cpu_addr_ok_o,
    output logic                       cpu_data_ok_o,
    output word_t                      cpu_rdata_o,
    output logic [index_w-1:0]         way_rd_index_o,
    output logic [tag_w-1:0]           way_lookup_tag_o,
    output logic [ways-1:0]            way_we_o,
    output logic [banks-1:0]           way_bank_mask_o,
    output logic [index_w-1:0]         way_wr_index_o,
    output logic [tag_w-1:0]           way_wr_tag_o,
    output line_t                      way_wr_line_o,
    input  logic [ways-1:0]            way_hit_i,
    input  logic [ways-1:0][tag_w-1:0] way_tag_i,
    input  line_t [ways-1:0]           way_line_i,
    output logic [index_w-1:0]         meta_index_o,
    output logic                       meta_fill_o,
    output logic                       meta_fill_way_o,
    output logic                       meta_fill_dirty_o,
    output logic                       meta_touch_o,
    output logic                       meta_touch_way_o,
    output logic                       meta_store_o,
    input  logic [ways-1:0]            meta_valid_i,
    input  logic                       meta_lru_i,
    input  logic                       meta_victim_dirty_i,
    output logic                       mem_req_valid_o,
    output mem_req_t                   mem_req_o,
    input  logic                       mem_req_ready_i,
    input  logic                       mem_resp_valid_i,
    input  line_t                      mem_resp_data_i
);

    ctrl_state_e       state_q;
    ctrl_state_e       state_d;
    cpu_req_t          req_q;
    logic              pend_q;  // lookup in flight
    logic              sent_q;  // memory request taken, waiting on response
    logic              done_q;
    logic              fwd_valid_q;
    logic [addr_w-3:0] fwd_addr_q;
    word_t             fwd_word_q;
    word_t             rdata_q;

    logic              accept;
    logic              lookup;
    logic              hit_way;
    logic              hit_done;
    logic              miss;
    logic              store_hit;
    logic              need_wb;
    logic              fill;
    logic              unc_done;
    logic              mem_fire;
    logic              resp_fire;
    logic [2:0]        word_sel;
    logic [index_w-1:0] req_index;
    word_t             cur_word;
    word_t             store_word;
    line_t             fill_line;

    function automatic word_t merge_word(word_t old_w, word_t new_w, logic [3:0] strb);
        word_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign word_sel  = req_q.addr[offset_w-1:2];
    assign req_index = req_q.addr[offset_w +: index_w];

    assign lookup    = (state_q == idle) && pend_q && !req_q.uncached;
    assign hit_way   = way_hit_i[1];
    assign hit_done  = lookup && (|way_hit_i);
    assign miss      = lookup && !(|way_hit_i);
    assign store_hit = hit_done && req_q.write;
    assign need_wb   = meta_valid_i[meta_lru_i] && meta_victim_dirty_i;

    assign mem_fire  = mem_req_valid_o && mem_req_ready_i;
    assign resp_fire = mem_resp_valid_i && sent_q;
    assign fill      = (state_q == refill) && resp_fire;
    assign unc_done  = (state_q == uncached) && (req_q.write ? mem_fire : resp_fire);

    assign cpu_addr_ok_o = (state_q == idle) && (!pend_q || hit_done);
    assign accept        = cpu_valid_i && cpu_addr_ok_o;

    // store committed last edge is not yet visible in the RAM output
    assign cur_word = (fwd_valid_q && fwd_addr_q == req_q.addr[addr_w-1:2]) ?
                      fwd_word_q : way_line_i[hit_way][word_sel];
    assign store_word = merge_word(cur_word, req_q.wdata, req_q.strb);

    assign cpu_data_ok_o = hit_done || done_q;
    assign cpu_rdata_o   = done_q ? rdata_q : cur_word;

    always_comb begin
        fill_line = mem_resp_data_i;
        if (req_q.write) begin
            fill_line[word_sel] = merge_word(mem_resp_data_i[word_sel], req_q.wdata, req_q.strb);
        end
    end

    // RAMs follow the new request on accept, else keep the current set
    assign way_rd_index_o   = accept ? cpu_req_i.addr[offset_w +: index_w] : req_index;
    assign way_lookup_tag_o = req_q.addr[addr_w-1 -: tag_w];
    assign way_we_o[0]      = (store_hit && !hit_way) || (fill && !meta_lru_i);
    assign way_we_o[1]      = (store_hit && hit_way) || (fill && meta_lru_i);
    assign way_bank_mask_o  = fill ? {banks{1'b1}} : (banks'(1) << word_sel);
    assign way_wr_index_o   = req_index;
    assign way_wr_tag_o     = req_q.addr[addr_w-1 -: tag_w];
    assign way_wr_line_o    = fill ? fill_line : {banks{store_word}};

    assign meta_index_o      = req_index;
    assign meta_fill_o       = fill;
    assign meta_fill_way_o   = meta_lru_i;
    assign meta_fill_dirty_o = req_q.write;  // write-allocate leaves the line dirty
    assign meta_touch_o      = hit_done;
    assign meta_touch_way_o  = hit_way;
    assign meta_store_o      = store_hit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle: begin
                if (pend_q && req_q.uncached) begin
                    state_d = uncached;
                end else if (miss && need_wb) begin
                    state_d = write_back;
                end else if (miss) begin
                    state_d = refill;
                end
            end
            write_back: begin
                if (mem_fire) begin
                    state_d = refill;
                end
            end
            refill: begin
                if (resp_fire) begin
                    state_d = idle;
                end
            end
            uncached: begin
                if (unc_done) begin
                    state_d = idle;
                end
            end
            default: state_d = idle;
        endcase
    end

    assign mem_req_valid_o = (state_q != idle) && !sent_q;

    always_comb begin
        mem_req_o.kind = line_read;
        mem_req_o.addr = {req_q.addr[addr_w-1:offset_w], {offset_w{1'b0}}};
        mem_req_o.strb = 4'hf;
        mem_req_o.data = '0;
        case (state_q)
            write_back: begin
                mem_req_o.kind = line_write;
                mem_req_o.addr = {way_tag_i[meta_lru_i], req_index, {offset_w{1'b0}}};
                mem_req_o.data = way_line_i[meta_lru_i];  // victim line
            end
            uncached: begin
                if (req_q.write) begin
                    mem_req_o.kind = word_write;
                end else begin
                    mem_req_o.kind = word_read;
                end
                mem_req_o.addr    = req_q.addr;
                mem_req_o.strb    = req_q.strb;
                mem_req_o.data[0] = req_q.wdata;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= idle;
            pend_q      <= 1'b0;
            sent_q      <= 1'b0;
            done_q      <= 1'b0;
            fwd_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            pend_q      <= accept;
            done_q      <= fill || unc_done;
            fwd_valid_q <= store_hit;
            if (state_d != state_q) begin
                sent_q <= 1'b0;
            end else if (mem_fire) begin
                sent_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req_i;
        end
        if (fill) begin
            rdata_q <= mem_resp_data_i[word_sel];
        end else if (unc_done) begin
            rdata_q <= mem_resp_data_i[0];
        end
        if (store_hit) begin
            fwd_addr_q <= req_q.addr[addr_w-1:2];
            fwd_word_q <= store_word;
        end
    end

endmodule

//--- source/dcache_top.sv
`timescale 1ns/10ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     cpu_valid_i,
    input  cpu_req_t cpu_req_i,
    output logic     cpu_addr_ok_o,
    output logic     cpu_data_ok_o,
    output word_t    cpu_rdata_o,
    output logic     mem_req_valid_o,
    output mem_req_t mem_req_o,
    input  logic     mem_req_ready_i,
    input  logic     mem_resp_valid_i,
    input  line_t    mem_resp_data_i
);

    logic [index_w-1:0]         rd_index;
    logic [tag_w-1:0]           lookup_tag;
    logic [ways-1:0]            way_we;
    logic [banks-1:0]           bank_mask;
    logic [index_w-1:0]         wr_index;
    logic [tag_w-1:0]           wr_tag;
    line_t                      wr_line;
    logic [ways-1:0]            way_hit;
    logic [ways-1:0][tag_w-1:0] way_tag;
    line_t [ways-1:0]           way_line;

    logic [index_w-1:0]         meta_index;
    logic                       meta_fill;
    logic                       meta_fill_way;
    logic                       meta_fill_dirty;
    logic                       meta_touch;
    logic                       meta_touch_way;
    logic                       meta_store;
    logic [ways-1:0]            meta_valid;
    logic                       meta_lru;
    logic                       meta_victim_dirty;

    dcache_ctrl u_ctrl (
        .clk                (clk),
        .reset              (reset),
        .cpu_valid_i        (cpu_valid_i),
        .cpu_req_i          (cpu_req_i),
        .cpu_addr_ok_o      (cpu_addr_ok_o),
        .cpu_data_ok_o      (cpu_data_ok_o),
        .cpu_rdata_o        (cpu_rdata_o),
        .way_rd_index_o     (rd_index),
        .way_lookup_tag_o   (lookup_tag),
        .way_we_o           (way_we),
        .way_bank_mask_o    (bank_mask),
        .way_wr_index_o     (wr_index),
        .way_wr_tag_o       (wr_tag),
        .way_wr_line_o      (wr_line),
        .way_hit_i          (way_hit),
        .way_tag_i          (way_tag),
        .way_line_i         (way_line),
        .meta_index_o       (meta_index),
        .meta_fill_o        (meta_fill),
        .meta_fill_way_o    (meta_fill_way),
        .meta_fill_dirty_o  (meta_fill_dirty),
        .meta_touch_o       (meta_touch),
        .meta_touch_way_o   (meta_touch_way),
        .meta_store_o       (meta_store),
        .meta_valid_i       (meta_valid),
        .meta_lru_i         (meta_lru),
        .meta_victim_dirty_i(meta_victim_dirty),
        .mem_req_valid_o    (mem_req_valid_o),
        .mem_req_o          (mem_req_o),
        .mem_req_ready_i    (mem_req_ready_i),
        .mem_resp_valid_i   (mem_resp_valid_i),
        .mem_resp_data_i    (mem_resp_data_i)
    );

    for (genvar w = 0; w < ways; w++) begin : g_way
        dcache_way u_way (
            .clk         (clk),
            .rd_index_i  (rd_index),
            .lookup_tag_i(lookup_tag),
            .valid_i     (meta_valid[w]),
            .we_i        (way_we[w]),
            .bank_mask_i (bank_mask),
            .wr_index_i  (wr_index),
            .wr_tag_i    (wr_tag),
            .wr_line_i   (wr_line),
            .hit_o       (way_hit[w]),
            .tag_o       (way_tag[w]),
            .line_o      (way_line[w])
        );
    end

    dcache_meta u_meta (
        .clk           (clk),
        .reset         (reset),
        .index_i       (meta_index),
        .fill_i        (meta_fill),
        .fill_way_i    (meta_fill_way),
        .fill_dirty_i  (meta_fill_dirty),
        .touch_i       (meta_touch),
        .touch_way_i   (meta_touch_way),
        .store_i       (meta_store),
        .valid_o       (meta_valid),
        .lru_o         (meta_lru),
        .victim_dirty_o(meta_victim_dirty)
    );

endmodule

//--- bench/dcache_asserts.sv
`timescale 1ns/10ps

module dcache_asserts
    import dcache_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     cpu_valid_i,
    input logic     cpu_addr_ok_o,
    input logic     cpu_data_ok_o,
    input logic     mem_req_valid_o,
    input mem_req_t mem_req_o,
    input logic     mem_req_ready_i
);

    int unsigned in_flight;  // accepted but not yet answered
    int unsigned fail_count = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= 0;
        end else begin
            case ({cpu_valid_i && cpu_addr_ok_o, cpu_data_ok_o})
                2'b10:   in_flight <= in_flight + 1;
                2'b01:   in_flight <= in_flight - 1;
                default: ;
            endcase
        end
    end

    hold_request: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
        else begin
            fail_count++;
            $error("memory request changed while ready was low");
        end

    quiet_in_reset: assert property (@(posedge clk)
        reset |=> !cpu_data_ok_o && !mem_req_valid_o)
        else begin
            fail_count++;
            $error("data_ok or memory request valid high during reset");
        end

    answered_once: assert property (@(posedge clk) disable iff (reset)
        cpu_data_ok_o |-> in_flight != 0)
        else begin
            fail_count++;
            $error("data_ok without an accepted request");
        end

endmodule

//--- bench/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int mem_words = 4096;  // 16 KB backing store

    logic     clk;
    logic     reset;
    logic     cpu_valid;
    cpu_req_t cpu_req;
    logic     addr_ok;
    logic     data_ok;
    word_t    rdata;
    logic     mem_valid;
    mem_req_t mem_req;
    logic     mem_ready;
    logic     resp_valid;
    line_t    resp_data;

    word_t    mem [mem_words];    // contents held by memory
    word_t    model [mem_words];  // value a load must return
    mem_req_t req_log [$];
    logic     stall_en;

    dcache_top DUT (
        .clk             (clk),
        .reset           (reset),
        .cpu_valid_i     (cpu_valid),
        .cpu_req_i       (cpu_req),
        .cpu_addr_ok_o   (addr_ok),
        .cpu_data_ok_o   (data_ok),
        .cpu_rdata_o     (rdata),
        .mem_req_valid_o (mem_valid),
        .mem_req_o       (mem_req),
        .mem_req_ready_i (mem_ready),
        .mem_resp_valid_i(resp_valid),
        .mem_resp_data_i (resp_data)
    );

    bind dcache_top dcache_asserts u_asserts (
        .clk            (clk),
        .reset          (reset),
        .cpu_valid_i    (cpu_valid_i),
        .cpu_addr_ok_o  (cpu_addr_ok_o),
        .cpu_data_ok_o  (cpu_data_ok_o),
        .mem_req_valid_o(mem_req_valid_o),
        .mem_req_o      (mem_req_o),
        .mem_req_ready_i(mem_req_ready_i)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    initial begin
        #20000;
        abort_run("watchdog expired before the tests finished");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string test, input word_t exp, input word_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s: expected %h, actual %h", test, exp, act));
        end
    endtask

    // only the fields that the request kind gives a meaning to
    task automatic check_req(input string test, input mem_req_t exp, input mem_req_t act);
        logic ok;
        ok = (act.kind === exp.kind) && (act.addr === exp.addr);
        if (exp.kind == word_write) begin
            ok = ok && (act.strb === exp.strb) && (act.data[0] === exp.data[0]);
        end
        if (exp.kind == line_write) begin
            ok = ok && (act.data === exp.data);
        end
        if (!ok) begin
            abort_run($sformatf("FAILED %s: expected %p, actual %p", test, exp, act));
        end
    endtask

    task automatic check_count(input string test, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("FAILED %s: expected %0d, actual %0d", test, exp, act));
        end
    endtask

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input logic [3:0] strb);
        word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'(addr[13:2]);
    endfunction

    function automatic line_t model_line(input logic [31:0] addr);
        line_t l;
        for (int b = 0; b < banks; b++) begin
            l[b] = model[word_index({addr[31:5], 5'b0}) + b];
        end
        return l;
    endfunction

    function automatic cpu_req_t make_req(input logic wr, input logic unc, input logic [3:0] strb,
                                          input logic [31:0] addr, input word_t wdata);
        cpu_req_t r;
        r.write    = wr;
        r.uncached = unc;
        r.strb     = strb;
        r.addr     = addr;
        r.wdata    = wdata;
        return r;
    endfunction

    // entered at a falling edge and left at the falling edge where data_ok is high
    task automatic cpu_access(input cpu_req_t req, output word_t data, output int lat);
        int waited;
        cpu_valid = 1'b1;
        cpu_req   = req;
        waited    = 0;
        while (!addr_ok) begin
            @(negedge clk);
            waited++;
            if (waited > 100) abort_run("a request was never accepted by the cache");
        end
        @(negedge clk);
        cpu_valid = 1'b0;
        lat       = 1;
        while (!data_ok) begin
            @(negedge clk);
            lat++;
            if (lat > 100) abort_run("data_ok never came for an accepted request");
        end
        data = rdata;
    endtask

    // memory model serves one request at a time
    initial begin
        mem_req_t first;
        int       base;
        mem_ready  = 1'b0;
        resp_valid = 1'b0;
        resp_data  = '0;
        forever begin
            @(negedge clk);
            if (mem_valid) begin
                first = mem_req;
                if (stall_en) begin
                    repeat ($urandom_range(5, 0)) @(negedge clk);
                end
                check_req("request held under stall", first, mem_req);
                req_log.push_back(first);
                base      = word_index(first.addr);
                mem_ready = 1'b1;
                @(negedge clk);
                mem_ready = 1'b0;
                case (first.kind)
                    line_write: begin
                        for (int b = 0; b < banks; b++) begin
                            mem[base + b] = first.data[b];
                        end
                    end
                    word_write: mem[base] = merge_bytes(mem[base], first.data[0], first.strb);
                    default: begin
                        repeat ($urandom_range(5, 0)) @(negedge clk);
                        resp_data = '0;
                        if (first.kind == line_read) begin
                            for (int b = 0; b < banks; b++) begin
                                resp_data[b] = mem[base + b];
                            end
                        end else begin
                            resp_data[0] = mem[base];
                        end
                        resp_valid = 1'b1;
                        @(negedge clk);
                        resp_valid = 1'b0;
                    end
                endcase
            end
        end
    end

    task automatic miss_then_hit(input string name, input logic [31:0] addr);
        mem_req_t exp;
        word_t    data;
        int       lat;
        req_log.delete();
        cpu_access(make_req(1'b0, 1'b0, 4'hf, addr, '0), data, lat);
        exp      = '0;
        exp.kind = line_read;
        exp.addr = {addr[31:5], 5'b0};
        check_count({name, " miss requests"}, 1, req_log.size());
        check_req(name, exp, req_log[0]);
        check_word(name, model[word_index(addr)], data);
        cpu_access(make_req(1'b0, 1'b0, 4'hf, addr ^ 32'h10, '0), data, lat);  // same line
        check_count({name, " hit requests"}, 1, req_log.size());
        check_count({name, " hit latency"}, 1, lat);
        check_word({name, " hit"}, model[word_index(addr ^ 32'h10)], data);
    endtask

    task automatic store_forward(input logic [31:0] addr);
        word_t data;
        word_t wdata;
        int    lat;
        cpu_access(make_req(1'b0, 1'b0, 4'hf, addr, '0), data, lat);
        req_log.delete();
        wdata = $urandom();
        model[word_index(addr)] = merge_bytes(model[word_index(addr)], wdata, 4'b0110);
        cpu_access(make_req(1'b1, 1'b0, 4'b0110, addr, wdata), data, lat);
        check_count("store hit latency", 1, lat);
        if (!addr_ok) abort_run("cache could not take a read in the cycle of a store hit");
        cpu_access(make_req(1'b0, 1'b0, 4'hf, addr, '0), data, lat);
        check_count("forwarded read latency", 1, lat);
        check_count("store hit requests", 0, req_log.size());
        check_word("store forward", model[word_index(addr)], data);
    endtask

    task automatic write_allocate(input logic [31:0] addr);
        mem_req_t exp;
        word_t    data;
        word_t    wdata;
        int       lat;
        req_log.delete();
        wdata = $urandom();
        model[word_index(addr)] = merge_bytes(model[word_index(addr)], wdata, 4'b1001);
        cpu_access(make_req(1'b1, 1'b0, 4'b1001, addr, wdata), data, lat);
        exp      = '0;
        exp.kind = line_read;
        exp.addr = {addr[31:5], 5'b0};
        check_count("store miss requests", 1, req_log.size());
        check_req("store miss", exp, req_log[0]);
        cpu_access(make_req(1'b0, 1'b0, 4'hf, addr, '0), data, lat);
        check_count("allocated read requests", 1, req_log.size());
        check_word("write allocate", model[word_index(addr)], data);
    endtask

    task automatic replace_dirty(input string name, input logic [index_w-1:0] index);
        logic [31:0] addr_a;
        logic [31:0] addr_b;
        logic [31:0] addr_c;
        mem_req_t    exp;
        word_t       data;
        word_t       wdata;
        int          lat;
        addr_a = {20'h1, index, 5'h08};
        addr_b = {20'h2, index, 5'h08};
        addr_c = {20'h3, index, 5'h08};
        wdata  = $urandom();
        cpu_access(make_req(1'b0, 1'b0, 4'hf, addr_a, '0), data, lat);
        model[word_index(addr_a)] = merge_bytes(model[word_index(addr_a)], wdata, 4'b0011);
        cpu_access(make_req(1'b1, 1'b0, 4'b0011, addr_a, wdata), data, lat);
        cpu_access(make_req(1'b0, 1'b0, 4'hf, addr_b, '0), data, lat);  // a is lru now
        req_log.delete();
        cpu_access(make_req(1'b0, 1'b0, 4'hf, addr_c, '0), data, lat);
        check_count({name, " requests"}, 2, req_log.size());
        exp      = '0;
        exp.kind = line_write;
        exp.addr = {addr_a[31:5], 5'b0};
        exp.data = model_line(addr_a);
        check_req({name, " writeback"}, exp, req_log[0]);
        exp.kind = line_read;
        exp.addr = {addr_c[31:5], 5'b0};
        check_req({name, " refill"}, exp, req_log[1]);
        check_word(name, model[word_index(addr_c)], data);
        cpu_access(make_req(1'b0, 1'b0, 4'hf, addr_a, '0), data, lat);
        check_word({name, " reload"}, model[word_index(addr_a)], data);
    endtask

    task automatic uncached_path(input logic [31:0] addr);
        mem_req_t exp;
        word_t    data;
        word_t    wdata;
        int       lat;
        req_log.delete();
        cpu_access(make_req(1'b0, 1'b1, 4'hf, addr, '0), data, lat);
        exp      = '0;
        exp.kind = word_read;
        exp.addr = addr;
        check_count("uncached read requests", 1, req_log.size());
        check_req("uncached read", exp, req_log[0]);
        check_word("uncached read", model[word_index(addr)], data);
        wdata = $urandom();
        model[word_index(addr)] = merge_bytes(model[word_index(addr)], wdata, 4'b1100);
        cpu_access(make_req(1'b1, 1'b1, 4'b1100, addr, wdata), data, lat);
        exp.kind    = word_write;
        exp.strb    = 4'b1100;
        exp.data[0] = wdata;
        check_count("uncached write requests", 2, req_log.size());
        check_req("uncached write", exp, req_log[1]);
        cpu_access(make_req(1'b0, 1'b1, 4'hf, addr, '0), data, lat);
        exp      = '0;
        exp.kind = word_read;
        exp.addr = addr;
        check_count("repeated uncached read requests", 3, req_log.size());
        check_req("repeated uncached read", exp, req_log[2]);
        check_word("repeated uncached read", model[word_index(addr)], data);
    endtask

    initial begin
        void'($urandom(32'h1656_8550));
        for (int i = 0; i < mem_words; i++) begin
            mem[i]   = $urandom();
            model[i] = mem[i];
        end
        stall_en  = 1'b0;
        cpu_valid = 1'b0;
        cpu_req   = '0;
        reset     = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        miss_then_hit("miss then hit", 32'h0000_0124);
        store_forward(32'h0000_0348);
        write_allocate(32'h0000_0564);
        replace_dirty("replacement", 7'h03);
        uncached_path(32'h0000_0f04);

        stall_en = 1'b1;  // random ready stalls from here on
        miss_then_hit("stalled miss then hit", 32'h0000_0a48);
        replace_dirty("stalled replacement", 7'h40);

        if (DUT.u_asserts.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- list.f
source/dcache_pkg.sv
source/cache_ram.sv
source/dcache_way.sv
source/dcache_meta.sv
source/dcache_ctrl.sv
source/dcache_top.sv
bench/dcache_asserts.sv
bench/dcache_tb.sv

//--- Makefile
SRCS := $(wildcard source/*.sv bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vdcache_tb: list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module dcache_tb -f list.f

run: obj_dir/Vdcache_tb
	./obj_dir/Vdcache_tb | tee sim.log
	@! grep -q "ERRORS FOUND" sim.log
	@grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
